// ==== Bender.yml ====
package:
  name: bitmanip_unit

sources:
  - hdl/bitmanip_pkg.sv
  - hdl/bitmanip_decoder.sv
  - hdl/bitmanip_apb_front.sv
  - hdl/bitmanip_job_fifo.sv
  - hdl/bitmanip_exec.sv
  - hdl/bitmanip_unit.sv
  - target: test
    files:
      - verification/bitmanip_unit_tb.sv

// ==== hdl/bitmanip_apb_front.sv ====
`timescale 1ns/1ns
`default_nettype none

module bitmanip_apb_front import bitmanip_pkg::*; #(
  parameter b_ext_e B_EXT = ZBA_ZBB_ZBS
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // APB slave
  input  logic      psel_i,
  input  logic      penable_i,
  input  logic      pwrite_i,
  input  apb_addr_t paddr_i,
  input  word_t     pwdata_i,
  output word_t     prdata_o,
  output logic      pready_o,
  output logic      pslverr_o,
  // Job push
  output logic      push_o,
  output alu_op_e   job_op_o,
  output word_t     job_a_o,
  output word_t     job_b_o,
  output logic      job_illegal_o,
  input  logic      full_i,
  // Result slot
  input  logic      res_valid_i,
  input  word_t     res_data_i,
  input  logic      res_illegal_i,
  output logic      res_take_o
);

  logic    wr_acc;       // Write access phase
  logic    rd_acc;       // Read access phase
  logic    instr_wr;
  word_t   rs1_q;
  word_t   rs2_q;
  word_t   instr_q;      // Last accepted instruction, readable
  alu_op_e dec_op;
  logic    dec_imm;
  logic    dec_illegal;
  shamt_t  shamt;
  word_t   rdata;
  logic    rd_err;
  logic    wr_err;

  assign wr_acc   = psel_i && penable_i && pwrite_i;
  assign rd_acc   = psel_i && penable_i && !pwrite_i;
  assign instr_wr = wr_acc && (paddr_i == ADDR_INSTR);

  // Decode straight from the write data
  bitmanip_decoder #(
    .B_EXT (B_EXT)
  ) u_decoder (
    .instr_i    (pwdata_i),
    .alu_op_o   (dec_op),
    .op_b_imm_o (dec_imm),
    .illegal_o  (dec_illegal)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Job assembly
  ////////////////////////////////////////////////////////////////////////////

  assign shamt         = pwdata_i[24:20];
  assign pready_o      = !(instr_wr && full_i);   // Back-pressure while full
  assign push_o        = instr_wr && !full_i;     // Push on the completing cycle
  assign job_op_o      = dec_op;
  assign job_a_o       = rs1_q;
  assign job_b_o       = dec_imm ? word_t'(shamt) : rs2_q;
  assign job_illegal_o = dec_illegal;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rs1_q   <= '0;
      rs2_q   <= '0;
      instr_q <= '0;
    end else if (wr_acc && pready_o) begin
      case (paddr_i)
        ADDR_RS1:   rs1_q   <= pwdata_i;
        ADDR_RS2:   rs2_q   <= pwdata_i;
        ADDR_INSTR: instr_q <= pwdata_i;
        default:    ;                            // Read-only or unmapped
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read mux and errors
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rdata  = '0;
    rd_err = 1'b0;
    case (paddr_i)
      ADDR_RS1:    rdata = rs1_q;
      ADDR_RS2:    rdata = rs2_q;
      ADDR_INSTR:  rdata = instr_q;
      ADDR_RESULT: begin
        if (res_valid_i) rdata = res_data_i;
        else rd_err = 1'b1;                      // Empty slot reads zero
      end
      ADDR_STATUS: begin
        rdata[STATUS_VALID_BIT]   = res_valid_i;
        rdata[STATUS_ILLEGAL_BIT] = res_illegal_i;
        rdata[STATUS_FULL_BIT]    = full_i;
      end
      default:     rd_err = 1'b1;
    endcase
  end

  // Only operand and instruction registers are writable
  assign wr_err = !(paddr_i inside {ADDR_RS1, ADDR_RS2, ADDR_INSTR});

  assign prdata_o   = rd_acc ? rdata : '0;
  assign pslverr_o  = (rd_acc && rd_err) || (wr_acc && wr_err);
  assign res_take_o = rd_acc && (paddr_i == ADDR_RESULT) && res_valid_i;

endmodule

`default_nettype wire

// ==== hdl/bitmanip_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module bitmanip_decoder import bitmanip_pkg::*; #(
  parameter b_ext_e B_EXT = NONE
) (
  input  word_t   instr_i,
  output alu_op_e alu_op_o,
  output logic    op_b_imm_o,   // B from shamt field instead of rs2
  output logic    illegal_o
);

  logic [6:0] funct7;
  logic [4:0] rs2_field;
  logic [2:0] funct3;
  logic       is_opimm;
  logic       ext_en;           // Extension set enable
  alu_op_e    op_d;             // Raw match before extension gating
  logic       op_en;

  assign funct7    = instr_i[31:25];
  assign rs2_field = instr_i[24:20];
  assign funct3    = instr_i[14:12];
  assign is_opimm  = (instr_i[6:0] == OPCODE_OPIMM);

  // Zba, Zbb and Zbs come and go together
  assign ext_en = (B_EXT == ZBA_ZBB_ZBS);

  ////////////////////////////////////////////////////////////////////////////
  // Encoding match
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    op_d = ALU_B_NOP;  // No match unless a case hits
    unique case (instr_i[6:0])
      OPCODE_OP: begin
        unique case ({funct7, funct3})
          {7'b001_0000, 3'b010}: op_d = SH1ADD;
          {7'b001_0000, 3'b100}: op_d = SH2ADD;
          {7'b001_0000, 3'b110}: op_d = SH3ADD;
          {7'b000_0101, 3'b100}: op_d = MIN;
          {7'b000_0101, 3'b101}: op_d = MINU;
          {7'b000_0101, 3'b110}: op_d = MAX;
          {7'b000_0101, 3'b111}: op_d = MAXU;
          {7'b010_0000, 3'b111}: op_d = ANDN;
          {7'b010_0000, 3'b110}: op_d = ORN;
          {7'b010_0000, 3'b100}: op_d = XNOR;
          {7'b011_0000, 3'b001}: op_d = ROL;
          {7'b011_0000, 3'b101}: op_d = ROR;
          {7'b001_0100, 3'b001}: op_d = BSET;
          {7'b010_0100, 3'b001}: op_d = BCLR;
          {7'b011_0100, 3'b001}: op_d = BINV;
          {7'b010_0100, 3'b101}: op_d = BEXT;   // Ratified funct3
          default:               op_d = ALU_B_NOP;
        endcase
      end
      OPCODE_OPIMM: begin
        // Unary ops also pin the rs2 field
        unique casez ({funct7, rs2_field, funct3})
          {7'b011_0000, 5'b0_0000, 3'b001}: op_d = CLZ;
          {7'b011_0000, 5'b0_0001, 3'b001}: op_d = CTZ;
          {7'b011_0000, 5'b0_0010, 3'b001}: op_d = CPOP;
          {7'b011_0000, 5'b0_0100, 3'b001}: op_d = SEXT_B;
          {7'b011_0000, 5'b0_0101, 3'b001}: op_d = SEXT_H;
          {7'b001_0100, 5'b0_0111, 3'b101}: op_d = ORC_B;
          {7'b011_0100, 5'b1_1000, 3'b101}: op_d = REV8;
          {7'b011_0000, 5'b?_????, 3'b101}: op_d = ROR;    // rori
          {7'b001_0100, 5'b?_????, 3'b001}: op_d = BSET;   // bseti
          {7'b010_0100, 5'b?_????, 3'b001}: op_d = BCLR;   // bclri
          {7'b011_0100, 5'b?_????, 3'b001}: op_d = BINV;   // binvi
          {7'b010_0100, 5'b?_????, 3'b101}: op_d = BEXT;   // bexti
          default:                          op_d = ALU_B_NOP;
        endcase
      end
      default: op_d = ALU_B_NOP;  // Other opcodes are not ours
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Extension gating
  ////////////////////////////////////////////////////////////////////////////

  // A match is legal only with the extension set enabled
  assign op_en = ext_en && (op_d != ALU_B_NOP);

  assign illegal_o  = !op_en;
  assign alu_op_o   = op_en ? op_d : ALU_B_NOP;
  // Immediate rotates and bit ops take B from the shamt field
  assign op_b_imm_o = op_en && is_opimm && (op_d inside {ROR, BSET, BCLR, BINV, BEXT});

endmodule

`default_nettype wire

// ==== hdl/bitmanip_exec.sv ====
`timescale 1ns/1ns
`default_nettype none

module bitmanip_exec import bitmanip_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  // FIFO head
  input  logic    empty_i,
  input  alu_op_e op_i,
  input  word_t   a_i,
  input  word_t   b_i,
  input  logic    illegal_i,
  output logic    pop_o,
  // Result slot
  input  logic    take_i,
  output logic    valid_o,
  output word_t   data_o,
  output logic    illegal_o
);

  logic        valid_q;
  word_t       data_q;
  logic        illegal_q;
  shamt_t      sh;          // Low five bits of B
  logic [63:0] rot_l;
  logic [63:0] rot_r;
  logic [5:0]  lz_cnt;
  logic [5:0]  tz_cnt;
  logic [5:0]  pop_cnt;
  word_t       result_d;

  // Slot free now or freed this cycle by the host read
  assign pop_o = !empty_i && (!valid_q || take_i);
  assign sh    = b_i[4:0];

  // Rotates off a doubled word
  assign rot_l = {a_i, a_i} << sh;
  assign rot_r = {a_i, a_i} >> sh;

  ////////////////////////////////////////////////////////////////////////////
  // Bit counts
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    logic lz_done;
    logic tz_done;
    lz_cnt  = '0;
    tz_cnt  = '0;
    pop_cnt = '0;
    lz_done = 1'b0;
    tz_done = 1'b0;
    for (int i = 0; i < 32; i++) begin
      if (a_i[31-i]) lz_done = 1'b1;             // Scan down from MSB
      else if (!lz_done) lz_cnt = lz_cnt + 1'b1;
      if (a_i[i]) tz_done = 1'b1;                // Scan up from LSB
      else if (!tz_done) tz_cnt = tz_cnt + 1'b1;
      if (a_i[i]) pop_cnt = pop_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Operator mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    result_d = '0;
    unique case (op_i)
      SH1ADD:  result_d = (a_i << 1) + b_i;
      SH2ADD:  result_d = (a_i << 2) + b_i;
      SH3ADD:  result_d = (a_i << 3) + b_i;
      MIN:     result_d = ($signed(a_i) < $signed(b_i)) ? a_i : b_i;
      MINU:    result_d = (a_i < b_i) ? a_i : b_i;
      MAX:     result_d = ($signed(a_i) < $signed(b_i)) ? b_i : a_i;
      MAXU:    result_d = (a_i < b_i) ? b_i : a_i;
      ANDN:    result_d = a_i & ~b_i;
      ORN:     result_d = a_i | ~b_i;
      XNOR:    result_d = ~(a_i ^ b_i);
      ROL:     result_d = rot_l[63:32];
      ROR:     result_d = rot_r[31:0];
      CLZ:     result_d = word_t'(lz_cnt);
      CTZ:     result_d = word_t'(tz_cnt);
      CPOP:    result_d = word_t'(pop_cnt);
      ORC_B: begin
        for (int i = 0; i < 4; i++) begin
          result_d[8*i +: 8] = (|a_i[8*i +: 8]) ? 8'hFF : 8'h00;
        end
      end
      REV8:    result_d = {a_i[7:0], a_i[15:8], a_i[23:16], a_i[31:24]};
      SEXT_B:  result_d = {{24{a_i[7]}}, a_i[7:0]};
      SEXT_H:  result_d = {{16{a_i[15]}}, a_i[15:0]};
      BSET:    result_d = a_i | (word_t'(1) << sh);
      BCLR:    result_d = a_i & ~(word_t'(1) << sh);
      BINV:    result_d = a_i ^ (word_t'(1) << sh);
      BEXT:    result_d = word_t'(a_i[sh]);
      default: result_d = '0;                    // NOP
    endcase
  end

  // Result slot, a pop overrides a take in the same cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q   <= 1'b0;
      data_q    <= '0;
      illegal_q <= 1'b0;
    end else if (pop_o) begin
      valid_q   <= 1'b1;
      data_q    <= illegal_i ? '0 : result_d;    // Illegal job reads zero
      illegal_q <= illegal_i;
    end else if (take_i) begin
      valid_q   <= 1'b0;
      data_q    <= '0;
      illegal_q <= 1'b0;
    end
  end

  assign valid_o   = valid_q;
  assign data_o    = data_q;
  assign illegal_o = illegal_q;

endmodule

`default_nettype wire

// ==== hdl/bitmanip_job_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module bitmanip_job_fifo import bitmanip_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  // Push side
  input  logic    push_i,
  input  alu_op_e op_i,
  input  word_t   a_i,
  input  word_t   b_i,
  input  logic    illegal_i,
  output logic    full_o,
  // Pop side, head valid while not empty
  input  logic    pop_i,
  output logic    empty_o,
  output alu_op_e op_o,
  output word_t   a_o,
  output word_t   b_o,
  output logic    illegal_o
);

  alu_op_e                op_q      [JOB_DEPTH];
  word_t                  a_q       [JOB_DEPTH];
  word_t                  b_q       [JOB_DEPTH];
  logic                   illegal_q [JOB_DEPTH];
  logic [JOB_PTR_W-1:0]   wr_ptr_q;
  logic [JOB_PTR_W-1:0]   rd_ptr_q;
  logic [JOB_CNT_W-1:0]   count_q;
  logic                   do_push;
  logic                   do_pop;

  // Wraps at JOB_DEPTH, not only powers of two
  function automatic logic [JOB_PTR_W-1:0] ptr_inc(input logic [JOB_PTR_W-1:0] ptr);
    return (ptr == JOB_PTR_W'(JOB_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == JOB_CNT_W'(JOB_DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      op_q[wr_ptr_q]      <= op_i;
      a_q[wr_ptr_q]       <= a_i;
      b_q[wr_ptr_q]       <= b_i;
      illegal_q[wr_ptr_q] <= illegal_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (do_pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;                               // Both or neither, no change
      endcase
    end
  end

  assign op_o      = op_q[rd_ptr_q];
  assign a_o       = a_q[rd_ptr_q];
  assign b_o       = b_q[rd_ptr_q];
  assign illegal_o = illegal_q[rd_ptr_q];

endmodule

`default_nettype wire

// ==== hdl/bitmanip_pkg.sv ====
`default_nettype none

package bitmanip_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data widths
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [31:0] word_t;      // Operands, results, instruction words
  typedef logic [7:0]  apb_addr_t;  // APB byte address
  typedef logic [4:0]  shamt_t;     // Shift amount / bit index

  // Supported extension sets
  typedef enum logic {
    NONE,
    ZBA_ZBB_ZBS
  } b_ext_e;

  // Operators handled by the execute unit
  typedef enum logic [4:0] {
    ALU_B_NOP,
    SH1ADD, SH2ADD, SH3ADD,         // Zba
    MIN, MINU, MAX, MAXU,           // Zbb compare
    ANDN, ORN, XNOR,                // Zbb logic with negate
    ROL, ROR,                       // Zbb rotates
    CLZ, CTZ, CPOP,                 // Zbb counts
    ORC_B, REV8, SEXT_B, SEXT_H,    // Zbb byte / extend ops
    BSET, BCLR, BINV, BEXT          // Zbs single-bit ops
  } alu_op_e;

  // Major opcodes carrying RV32B instructions
  typedef enum logic [6:0] {
    OPCODE_OP    = 7'h33,
    OPCODE_OPIMM = 7'h13
  } opcode_e;

  ////////////////////////////////////////////////////////////////////////////
  // Job FIFO sizing
  ////////////////////////////////////////////////////////////////////////////

  localparam int JOB_DEPTH = 4;
  localparam int JOB_PTR_W = $clog2(JOB_DEPTH);
  localparam int JOB_CNT_W = $clog2(JOB_DEPTH + 1);  // Count must reach JOB_DEPTH

  ////////////////////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////////////////////

  localparam apb_addr_t ADDR_RS1    = 8'h00;  // Operand A
  localparam apb_addr_t ADDR_RS2    = 8'h04;  // Operand B
  localparam apb_addr_t ADDR_INSTR  = 8'h08;  // Write launches a job
  localparam apb_addr_t ADDR_RESULT = 8'h0C;  // Read frees the slot
  localparam apb_addr_t ADDR_STATUS = 8'h10;

  // STATUS bit positions
  localparam int STATUS_VALID_BIT   = 0;
  localparam int STATUS_ILLEGAL_BIT = 1;
  localparam int STATUS_FULL_BIT    = 2;

endpackage

`default_nettype wire

// ==== hdl/bitmanip_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module bitmanip_unit import bitmanip_pkg::*; #(
  parameter b_ext_e B_EXT = ZBA_ZBB_ZBS
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      psel_i,
  input  logic      penable_i,
  input  logic      pwrite_i,
  input  apb_addr_t paddr_i,
  input  word_t     pwdata_i,
  output word_t     prdata_o,
  output logic      pready_o,
  output logic      pslverr_o
);

  // Front end to FIFO
  logic    push;
  alu_op_e job_op;
  word_t   job_a;
  word_t   job_b;
  logic    job_illegal;
  logic    full;
  // FIFO head to execute unit
  logic    pop;
  logic    empty;
  alu_op_e head_op;
  word_t   head_a;
  word_t   head_b;
  logic    head_illegal;
  // Result slot back to front end
  logic    res_valid;
  word_t   res_data;
  logic    res_illegal;
  logic    res_take;

  bitmanip_apb_front #(
    .B_EXT (B_EXT)
  ) u_front (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .paddr_i       (paddr_i),
    .pwdata_i      (pwdata_i),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o),
    .push_o        (push),
    .job_op_o      (job_op),
    .job_a_o       (job_a),
    .job_b_o       (job_b),
    .job_illegal_o (job_illegal),
    .full_i        (full),
    .res_valid_i   (res_valid),
    .res_data_i    (res_data),
    .res_illegal_i (res_illegal),
    .res_take_o    (res_take)
  );

  bitmanip_job_fifo u_fifo (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .push_i    (push),
    .op_i      (job_op),
    .a_i       (job_a),
    .b_i       (job_b),
    .illegal_i (job_illegal),
    .full_o    (full),
    .pop_i     (pop),
    .empty_o   (empty),
    .op_o      (head_op),
    .a_o       (head_a),
    .b_o       (head_b),
    .illegal_o (head_illegal)
  );

  bitmanip_exec u_exec (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .empty_i   (empty),
    .op_i      (head_op),
    .a_i       (head_a),
    .b_i       (head_b),
    .illegal_i (head_illegal),
    .pop_o     (pop),
    .take_i    (res_take),
    .valid_o   (res_valid),
    .data_o    (res_data),
    .illegal_o (res_illegal)
  );

endmodule

`default_nettype wire

// ==== list.f ====
hdl/bitmanip_pkg.sv
hdl/bitmanip_decoder.sv
hdl/bitmanip_apb_front.sv
hdl/bitmanip_job_fifo.sv
hdl/bitmanip_exec.sv
hdl/bitmanip_unit.sv
verification/bitmanip_unit_tb.sv

// ==== verification/bitmanip_unit_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module bitmanip_unit_tb import bitmanip_pkg::*; ();

  localparam int MAX_CASES = 40;

  logic      clk;
  logic      rst_n;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  word_t     pwdata;
  word_t     prdata;
  logic      pready;
  logic      pslverr;

  // Stimulus table, one row per instruction
  string     case_name  [MAX_CASES];
  word_t     case_a     [MAX_CASES];
  word_t     case_b     [MAX_CASES];
  word_t     case_instr [MAX_CASES];
  word_t     case_exp   [MAX_CASES];
  logic      case_ill   [MAX_CASES];
  int        n_cases;

  int        cycle_cnt;
  int        cycle_limit;

  bitmanip_unit #(
    .B_EXT (ZBA_ZBB_ZBS)
  ) uut (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr)
  );

  always #50 clk = ~clk;  // 100 ns period

  // Hang guard, limit set from table length
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Something failed");
      $fatal(1, "run stopped by cycle limit");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("mismatch in %s: expected %h, actual %h", name, exp, act);
      $display("Something failed");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch in %s: expected %b, actual %b", name, exp, act);
      $display("Something failed");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch in %s pslverr: expected %b, actual %b", name, exp, act);
      $display("Something failed");
      $fatal(1, "stopped at first error");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // APB driver
  ////////////////////////////////////////////////////////////////////////////

  // Setup then access, outputs sampled 1 ns after the falling edge
  task automatic apb_write(input apb_addr_t addr, input word_t data, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    #1;
    while (!pready) begin     // Wait states
      @(negedge clk);
      #1;
    end
    err = pslverr;
    @(negedge clk);           // Completed on the rising edge before
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output word_t data, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    #1;
    while (!pready) begin
      @(negedge clk);
      #1;
    end
    data = prdata;
    err  = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // Access phase held with pready low, then the transfer is withdrawn
  task automatic write_expect_stall(input apb_addr_t addr, input word_t data, input int n);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    repeat (n) begin
      #1;
      check_flag("stalled INSTR write pready", 1'b0, pready);
      @(negedge clk);
    end
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Table helpers
  ////////////////////////////////////////////////////////////////////////////

  // R-type in OP, rd=x3 rs1=x1 rs2=x2
  function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3);
    return {f7, 5'd2, 5'd1, f3, 5'd3, 7'h33};
  endfunction

  // OP-IMM, the rs2 slot carries shamt or unary selector
  function automatic word_t enc_i(input logic [6:0] f7, input logic [4:0] sel,
                                  input logic [2:0] f3);
    return {f7, sel, 5'd1, f3, 5'd3, 7'h13};
  endfunction

  task automatic add_case(input string name, input word_t a, input word_t b,
                          input word_t instr, input word_t exp, input logic ill);
    case_name[n_cases]  = name;
    case_a[n_cases]     = a;
    case_b[n_cases]     = b;
    case_instr[n_cases] = instr;
    case_exp[n_cases]   = exp;
    case_ill[n_cases]   = ill;
    n_cases = n_cases + 1;
  endtask

  task automatic send_job(input int idx);
    logic err;
    apb_write(ADDR_RS1, case_a[idx], err);
    check_err({case_name[idx], " RS1 write"}, 1'b0, err);
    apb_write(ADDR_RS2, case_b[idx], err);
    check_err({case_name[idx], " RS2 write"}, 1'b0, err);
    apb_write(ADDR_INSTR, case_instr[idx], err);
    check_err({case_name[idx], " INSTR write"}, 1'b0, err);
  endtask

  // Poll STATUS for valid, then read and check RESULT
  task automatic collect_result(input int idx);
    word_t st;
    word_t res;
    logic  err;
    do begin
      apb_read(ADDR_STATUS, st, err);
      check_err({case_name[idx], " STATUS read"}, 1'b0, err);
    end while (!st[STATUS_VALID_BIT]);
    check_flag({case_name[idx], " illegal"}, case_ill[idx], st[STATUS_ILLEGAL_BIT]);
    apb_read(ADDR_RESULT, res, err);
    check_err({case_name[idx], " RESULT read"}, 1'b0, err);
    check_word(case_name[idx], case_exp[idx], res);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    word_t rd;
    logic  err;
    clk       = 1'b0;
    rst_n     = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    n_cases   = 0;
    cycle_cnt = 0;

    // Register forms                 rs1            rs2
    add_case("sh1add", 32'h1234_5678, 32'h0000_0010, enc_r(7'h10, 3'h2), 32'h2468_AD00, 1'b0);
    add_case("sh2add", 32'h1234_5678, 32'h0000_0010, enc_r(7'h10, 3'h4), 32'h48D1_59F0, 1'b0);
    add_case("sh3add", 32'h1234_5678, 32'h0000_0010, enc_r(7'h10, 3'h6), 32'h91A2_B3D0, 1'b0);
    add_case("min",    32'hF000_0001, 32'h0000_0010, enc_r(7'h05, 3'h4), 32'hF000_0001, 1'b0);
    add_case("minu",   32'hF000_0001, 32'h0000_0010, enc_r(7'h05, 3'h5), 32'h0000_0010, 1'b0);
    add_case("max",    32'hF000_0001, 32'h0000_0010, enc_r(7'h05, 3'h6), 32'h0000_0010, 1'b0);
    add_case("maxu",   32'hF000_0001, 32'h0000_0010, enc_r(7'h05, 3'h7), 32'hF000_0001, 1'b0);
    add_case("andn",   32'hFF00_FF00, 32'h0F0F_0F0F, enc_r(7'h20, 3'h7), 32'hF000_F000, 1'b0);
    add_case("orn",    32'hFF00_FF00, 32'h0F0F_0F0F, enc_r(7'h20, 3'h6), 32'hFFF0_FFF0, 1'b0);
    add_case("xnor",   32'hFF00_FF00, 32'h0F0F_0F0F, enc_r(7'h20, 3'h4), 32'h0FF0_0FF0, 1'b0);
    add_case("rol",    32'h8000_0001, 32'hFFFF_FFE4, enc_r(7'h30, 3'h1), 32'h0000_0018, 1'b0);
    add_case("ror",    32'h8000_0001, 32'h0000_0024, enc_r(7'h30, 3'h5), 32'h1800_0000, 1'b0);
    add_case("bset",   32'h0000_00F0, 32'h0000_0028, enc_r(7'h14, 3'h1), 32'h0000_01F0, 1'b0);
    add_case("bclr",   32'hFFFF_FFFF, 32'h0000_001F, enc_r(7'h24, 3'h1), 32'h7FFF_FFFF, 1'b0);
    add_case("binv",   32'h0000_00F0, 32'h0000_0004, enc_r(7'h34, 3'h1), 32'h0000_00E0, 1'b0);
    add_case("bext",   32'h0000_0400, 32'h0000_000A, enc_r(7'h24, 3'h5), 32'h0000_0001, 1'b0);
    // Immediate forms, rs2 would give another result
    add_case("rori",  32'h1234_5678, 32'h0, enc_i(7'h30, 5'd8, 3'h5), 32'h7812_3456, 1'b0);
    add_case("bseti", 32'h0000_0000, 32'h5, enc_i(7'h14, 5'd3, 3'h1), 32'h0000_0008, 1'b0);
    add_case("bclri", 32'hFFFF_FFFF, 32'h1, enc_i(7'h24, 5'd0, 3'h1), 32'hFFFF_FFFE, 1'b0);
    add_case("binvi", 32'h0000_0000, 32'h0, enc_i(7'h34, 5'd31, 3'h1), 32'h8000_0000, 1'b0);
    add_case("bexti", 32'h0000_0004, 32'h3, enc_i(7'h24, 5'd2, 3'h5), 32'h0000_0001, 1'b0);
    // Unary forms
    add_case("clz",    32'h0001_0000, '1, enc_i(7'h30, 5'h00, 3'h1), 32'h0000_000F, 1'b0);
    add_case("clz0",   32'h0000_0000, '1, enc_i(7'h30, 5'h00, 3'h1), 32'h0000_0020, 1'b0);
    add_case("ctz",    32'h0001_0000, '1, enc_i(7'h30, 5'h01, 3'h1), 32'h0000_0010, 1'b0);
    add_case("cpop",   32'hF0F0_0001, '1, enc_i(7'h30, 5'h02, 3'h1), 32'h0000_0009, 1'b0);
    add_case("orc.b",  32'h0010_0300, '1, enc_i(7'h14, 5'h07, 3'h5), 32'h00FF_FF00, 1'b0);
    add_case("rev8",   32'h1234_5678, '1, enc_i(7'h34, 5'h18, 3'h5), 32'h7856_3412, 1'b0);
    add_case("sext.b", 32'h0000_0080, '1, enc_i(7'h30, 5'h04, 3'h1), 32'hFFFF_FF80, 1'b0);
    add_case("sext.h", 32'h1234_8001, '1, enc_i(7'h30, 5'h05, 3'h1), 32'hFFFF_8001, 1'b0);
    // Illegal encodings read zero
    add_case("bad funct7", 32'h1, 32'h2, enc_r(7'h7F, 3'h0), 32'h0, 1'b1);
    add_case("bad opcode", 32'h1, 32'h2,
             {7'h30, 5'd0, 5'd1, 3'h1, 5'd3, 7'h03}, 32'h0, 1'b1);
    add_case("clz bad rs2", 32'h1, 32'h2, enc_i(7'h30, 5'h03, 3'h1), 32'h0, 1'b1);

    cycle_limit = 40 * n_cases + 200;

    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    // Idle state after reset
    apb_read(ADDR_STATUS, rd, err);
    check_err("reset STATUS", 1'b0, err);
    check_word("reset STATUS", '0, rd);
    apb_read(ADDR_RESULT, rd, err);
    check_err("reset RESULT", 1'b1, err);
    check_word("reset RESULT", '0, rd);

    for (int i = 0; i < n_cases; i++) begin
      send_job(i);
      collect_result(i);
    end

    // Back-pressure, four in the FIFO and one in the slot
    for (int i = 0; i < 5; i++) begin
      send_job(i);
    end
    apb_read(ADDR_STATUS, rd, err);
    check_err("full STATUS", 1'b0, err);
    check_word("full STATUS", (word_t'(1) << STATUS_VALID_BIT) |
               (word_t'(1) << STATUS_FULL_BIT), rd);
    apb_write(ADDR_RS1, case_a[5], err);
    check_err("sixth RS1 write", 1'b0, err);
    apb_write(ADDR_RS2, case_b[5], err);
    check_err("sixth RS2 write", 1'b0, err);
    write_expect_stall(ADDR_INSTR, case_instr[5], 5);
    collect_result(0);                           // Frees one FIFO entry
    apb_write(ADDR_INSTR, case_instr[5], err);
    check_err("sixth INSTR write", 1'b0, err);
    for (int i = 1; i < 6; i++) begin
      collect_result(i);                         // Results in push order
    end

    // Unmapped addresses
    apb_read(8'h14, rd, err);
    check_err("unmapped read", 1'b1, err);
    apb_write(8'h40, 32'hDEAD_BEEF, err);
    check_err("unmapped write", 1'b1, err);

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire
